// File: Bender.yml
package:
  name: perf_monitor

sources:
  - files:
      - design/perf_pkg.sv
      - design/perf_snoop.sv
      - design/perf_event_counter.sv
      - design/perf_csr.sv
      - design/perf_monitor.sv
  - target: test
    files:
      - testbench/perf_clock_gen.sv
      - testbench/perf_asserts.sv
      - testbench/perf_tb.sv

// File: build.f
design/perf_pkg.sv
design/perf_snoop.sv
design/perf_event_counter.sv
design/perf_csr.sv
design/perf_monitor.sv
testbench/perf_clock_gen.sv
testbench/perf_asserts.sv
testbench/perf_tb.sv

// File: design/perf_csr.sv
module perf_csr (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic [perf_pkg::csr_addr_width-1:0] csr_address,
	input  logic                                csr_read,
	input  logic                                csr_write,
	input  logic [perf_pkg::word_width-1:0]     csr_writedata,
	output logic [perf_pkg::word_width-1:0]     csr_readdata, // Valid one cycle after csr_read

	input  logic [perf_pkg::num_events*perf_pkg::counter_width-1:0] counts,
	input  logic [perf_pkg::word_width-1:0]                         last_address,

	output logic                                count_enable,
	output logic                                count_clear
);

	logic                            ctrl_write;
	logic [perf_pkg::word_width-1:0] read_value;

	// ==============================
	// Control register
	// ==============================

	assign ctrl_write  = csr_write && (csr_address == perf_pkg::csr_ctrl);
	assign count_clear = ctrl_write && csr_writedata[perf_pkg::ctrl_clear_bit]; // Lasts as long as the strobe

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_enable <= 1'b0;
		end else if (ctrl_write) begin
			count_enable <= csr_writedata[perf_pkg::ctrl_enable_bit];
		end
	end

	// ==============================
	// Read path
	// ==============================

	always_comb begin
		read_value = '0; // Unmapped addresses read as zero

		if (csr_address == perf_pkg::csr_ctrl) begin
			read_value[perf_pkg::ctrl_enable_bit] = count_enable;
		end else if (csr_address == perf_pkg::csr_last_addr) begin
			read_value = last_address;
		end

		for (int i = 0; i < perf_pkg::num_events; i++) begin
			if (csr_address == perf_pkg::csr_counter_base + i) begin
				read_value = counts[i*perf_pkg::counter_width +: perf_pkg::counter_width];
			end
		end
	end

	// A write in the same cycle lands after this sample, so reads see the old value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_readdata <= '0;
		end else if (csr_read) begin
			csr_readdata <= read_value;
		end
	end

endmodule

// File: design/perf_event_counter.sv
module perf_event_counter (
	input  logic                            clk,
	input  logic                            rst_n,

	input  logic                            count_enable,
	input  logic                            count_clear, // One-cycle pulse, wins over counting

	input  logic                            snoop_left_valid,
	input  logic                            snoop_left_ready,
	input  logic                            snoop_right_valid,
	input  logic                            snoop_right_ready,
	input  logic                            snoop_read,
	input  logic                            snoop_write,
	input  logic                            snoop_waitrequest,
	input  logic [perf_pkg::word_width-1:0] snoop_address,
	input  logic                            snoop_left_read,
	input  logic                            snoop_left_inval,
	input  logic                            snoop_left_reply,
	input  logic                            snoop_right_read,
	input  logic                            snoop_right_inval,
	input  logic                            snoop_right_reply,

	output logic [perf_pkg::num_events*perf_pkg::counter_width-1:0] counts,
	output logic [perf_pkg::word_width-1:0]                         last_address
);

	logic left_xfer;
	logic right_xfer;
	logic mem_busy;
	logic mem_done;

	// Up to 2 per cycle when both segments carry the same flag
	logic [1:0] incr [perf_pkg::num_events];

	logic [perf_pkg::counter_width-1:0] count_q [perf_pkg::num_events];

	// ==============================
	// Event decode
	// ==============================

	assign left_xfer  = snoop_left_valid & snoop_left_ready;
	assign right_xfer = snoop_right_valid & snoop_right_ready;
	assign mem_busy   = snoop_read | snoop_write;
	assign mem_done   = mem_busy & ~snoop_waitrequest;

	always_comb begin
		incr[perf_pkg::ev_left_xfer]  = {1'b0, left_xfer};
		incr[perf_pkg::ev_left_stall] = {1'b0, snoop_left_valid & ~snoop_left_ready};
		incr[perf_pkg::ev_right_xfer] = {1'b0, right_xfer};

		incr[perf_pkg::ev_ring_read] = {1'b0, left_xfer & snoop_left_read}
			+ {1'b0, right_xfer & snoop_right_read};
		incr[perf_pkg::ev_ring_inval] = {1'b0, left_xfer & snoop_left_inval}
			+ {1'b0, right_xfer & snoop_right_inval};
		incr[perf_pkg::ev_ring_reply] = {1'b0, left_xfer & snoop_left_reply}
			+ {1'b0, right_xfer & snoop_right_reply};

		incr[perf_pkg::ev_mem_access] = {1'b0, mem_done};
		incr[perf_pkg::ev_mem_wait]   = {1'b0, mem_busy & snoop_waitrequest};
	end

	// ==============================
	// Counters
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < perf_pkg::num_events; i++) begin
				count_q[i] <= '0;
			end
		end else if (count_clear) begin
			for (int i = 0; i < perf_pkg::num_events; i++) begin
				count_q[i] <= '0;
			end
		end else if (count_enable) begin
			for (int i = 0; i < perf_pkg::num_events; i++) begin
				count_q[i] <= count_q[i] + {{(perf_pkg::counter_width - 2){1'b0}}, incr[i]};
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_address <= '0;
		end else if (count_clear) begin
			last_address <= '0;
		end else if (count_enable && mem_done) begin
			last_address <= snoop_address; // Address of the latest completed access
		end
	end

	for (genvar g = 0; g < perf_pkg::num_events; g++) begin : g_flatten
		assign counts[g*perf_pkg::counter_width +: perf_pkg::counter_width] = count_q[g];
	end

endmodule

// File: design/perf_monitor.sv
module perf_monitor (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic                                in_left_valid,
	input  logic [perf_pkg::ttl_width-1:0]      in_left_ttl,
	input  logic                                in_left_read,
	input  logic                                in_left_inval,
	input  logic                                in_left_reply,
	input  logic [perf_pkg::line_ptr_width-1:0] in_left_address,
	output logic                                in_left_ready,

	input  logic                                out_left_ready,
	output logic                                out_left_valid,
	output logic [perf_pkg::ttl_width-1:0]      out_left_ttl,
	output logic                                out_left_read,
	output logic                                out_left_inval,
	output logic                                out_left_reply,
	output logic [perf_pkg::line_ptr_width-1:0] out_left_address,

	input  logic                                in_right_valid,
	input  logic                                in_right_ready,
	input  logic [perf_pkg::ttl_width-1:0]      in_right_ttl,
	input  logic                                in_right_read,
	input  logic                                in_right_inval,
	input  logic                                in_right_reply,

	input  logic [perf_pkg::line_ptr_width-1:0] local_address,
	input  logic                                local_read,
	input  logic                                local_write,
	input  logic [perf_pkg::line_width-1:0]     local_writedata,
	input  logic [perf_pkg::be_width-1:0]       local_byteenable,
	output logic                                local_waitrequest,
	output logic [perf_pkg::line_width-1:0]     local_readdata,

	input  logic                                mem_waitrequest,
	input  logic [perf_pkg::line_width-1:0]     mem_readdata,
	output logic [perf_pkg::word_width-1:0]     mem_address,
	output logic                                mem_read,
	output logic                                mem_write,
	output logic [perf_pkg::line_width-1:0]     mem_writedata,
	output logic [perf_pkg::be_width-1:0]       mem_byteenable,

	input  logic [perf_pkg::csr_addr_width-1:0] csr_address,
	input  logic                                csr_read,
	input  logic                                csr_write,
	input  logic [perf_pkg::word_width-1:0]     csr_writedata,
	output logic [perf_pkg::word_width-1:0]     csr_readdata
);

	logic snoop_left_valid, snoop_left_ready, snoop_right_valid, snoop_right_ready;
	logic snoop_read, snoop_write, snoop_waitrequest;
	logic snoop_left_read, snoop_left_inval, snoop_left_reply;
	logic snoop_right_read, snoop_right_inval, snoop_right_reply;
	logic [perf_pkg::word_width-1:0] snoop_address;

	logic count_enable;
	logic count_clear;
	logic [perf_pkg::num_events*perf_pkg::counter_width-1:0] counts;
	logic [perf_pkg::word_width-1:0] last_address;

	// No event uses the sampled ttl, so those snoop outputs stay open here
	perf_snoop snoop (
		.snoop_left_ttl(),
		.snoop_right_ttl(),
		.*
	);

	perf_event_counter counter (.*);

	perf_csr csr (.*);

endmodule

// File: design/perf_pkg.sv
package perf_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int line_width     = 128; // One cache line
	localparam int line_ptr_width = 28;  // Line address, 16 bytes per line
	localparam int word_width     = 32;  // Byte address and register data
	localparam int be_width       = 16;  // One enable per byte of a line
	localparam int ttl_width      = 2;
	localparam int counter_width  = 32;
	localparam int num_events     = 8;
	localparam int csr_addr_width = 4;

	// ==============================
	// Event indices
	// ==============================

	// Each index is also the counter position in the flat counts vector
	localparam int ev_left_xfer  = 0;
	localparam int ev_left_stall = 1; // Valid without ready on the left segment
	localparam int ev_right_xfer = 2;
	localparam int ev_ring_read  = 3; // Counted on both segments
	localparam int ev_ring_inval = 4;
	localparam int ev_ring_reply = 5;
	localparam int ev_mem_access = 6; // Completed read or write
	localparam int ev_mem_wait   = 7; // Cycle stalled by waitrequest

	// ==============================
	// Register map
	// ==============================

	localparam logic [csr_addr_width-1:0] csr_ctrl         = 4'd0;
	localparam logic [csr_addr_width-1:0] csr_counter_base = 4'd1; // Counters at 1 to 8
	localparam logic [csr_addr_width-1:0] csr_last_addr    = 4'd9;

	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_clear_bit  = 1; // Write only, reads back as 0

endpackage

// File: design/perf_snoop.sv
module perf_snoop (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic                                in_left_valid,
	input  logic [perf_pkg::ttl_width-1:0]      in_left_ttl,
	input  logic                                in_left_read,
	input  logic                                in_left_inval,
	input  logic                                in_left_reply,
	input  logic [perf_pkg::line_ptr_width-1:0] in_left_address,
	output logic                                in_left_ready,

	input  logic                                out_left_ready,
	output logic                                out_left_valid,
	output logic [perf_pkg::ttl_width-1:0]      out_left_ttl,
	output logic                                out_left_read,
	output logic                                out_left_inval,
	output logic                                out_left_reply,
	output logic [perf_pkg::line_ptr_width-1:0] out_left_address,

	input  logic                                in_right_valid,
	input  logic                                in_right_ready,
	input  logic [perf_pkg::ttl_width-1:0]      in_right_ttl,
	input  logic                                in_right_read,
	input  logic                                in_right_inval,
	input  logic                                in_right_reply,

	input  logic [perf_pkg::line_ptr_width-1:0] local_address,
	input  logic                                local_read,
	input  logic                                local_write,
	input  logic [perf_pkg::line_width-1:0]     local_writedata,
	input  logic [perf_pkg::be_width-1:0]       local_byteenable,
	output logic                                local_waitrequest,
	output logic [perf_pkg::line_width-1:0]     local_readdata,

	input  logic                                mem_waitrequest,
	input  logic [perf_pkg::line_width-1:0]     mem_readdata,
	output logic [perf_pkg::word_width-1:0]     mem_address,
	output logic                                mem_read,
	output logic                                mem_write,
	output logic [perf_pkg::line_width-1:0]     mem_writedata,
	output logic [perf_pkg::be_width-1:0]       mem_byteenable,

	output logic                                snoop_left_valid,
	output logic                                snoop_left_ready,
	output logic                                snoop_right_valid,
	output logic                                snoop_right_ready,
	output logic                                snoop_read,
	output logic                                snoop_write,
	output logic                                snoop_waitrequest,
	output logic [perf_pkg::word_width-1:0]     snoop_address,
	output logic [perf_pkg::ttl_width-1:0]      snoop_left_ttl,
	output logic                                snoop_left_read,
	output logic                                snoop_left_inval,
	output logic                                snoop_left_reply,
	output logic [perf_pkg::ttl_width-1:0]      snoop_right_ttl,
	output logic                                snoop_right_read,
	output logic                                snoop_right_inval,
	output logic                                snoop_right_reply
);

	// The hold stage keeps the handshake levels first and then the flags and address
	logic [6:0]                          hold_ctrl;
	logic [2*(perf_pkg::ttl_width+3)-1:0] hold_flags;
	logic [perf_pkg::word_width-1:0]     hold_address;

	// ==============================
	// Pass-through
	// ==============================

	assign in_left_ready    = out_left_ready;
	assign out_left_valid   = in_left_valid;
	assign out_left_ttl     = in_left_ttl;
	assign out_left_read    = in_left_read;
	assign out_left_inval   = in_left_inval;
	assign out_left_reply   = in_left_reply;
	assign out_left_address = in_left_address;

	assign mem_read          = local_read;
	assign mem_write         = local_write;
	assign mem_writedata     = local_writedata;
	assign mem_byteenable    = local_byteenable;
	assign mem_address       = {local_address,
		{(perf_pkg::word_width - perf_pkg::line_ptr_width){1'b0}}};
	assign local_readdata    = mem_readdata;
	assign local_waitrequest = mem_waitrequest;

	// ==============================
	// Sampling
	// ==============================

	// Two stages so the counters can sit far from the ring
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_ctrl     <= '0;
			hold_flags    <= '0;
			hold_address  <= '0;
			snoop_address <= '0;
			{snoop_left_valid, snoop_left_ready, snoop_right_valid, snoop_right_ready,
			 snoop_read, snoop_write, snoop_waitrequest} <= '0;
			{snoop_left_ttl, snoop_left_read, snoop_left_inval, snoop_left_reply,
			 snoop_right_ttl, snoop_right_read, snoop_right_inval, snoop_right_reply} <= '0;
		end else begin
			hold_ctrl <= {in_left_valid, out_left_ready, in_right_valid, in_right_ready,
				local_read, local_write, mem_waitrequest};
			hold_flags <= {in_left_ttl, in_left_read, in_left_inval, in_left_reply,
				in_right_ttl, in_right_read, in_right_inval, in_right_reply};
			hold_address <= mem_address;

			{snoop_left_valid, snoop_left_ready, snoop_right_valid, snoop_right_ready,
			 snoop_read, snoop_write, snoop_waitrequest} <= hold_ctrl;
			{snoop_left_ttl, snoop_left_read, snoop_left_inval, snoop_left_reply,
			 snoop_right_ttl, snoop_right_read, snoop_right_inval, snoop_right_reply} <= hold_flags;
			snoop_address <= hold_address;
		end
	end

endmodule

// File: testbench/perf_asserts.sv
module perf_asserts (
	input logic        clk,
	input logic        rst_n,
	input logic [48:0] in_sample,    // Handshake levels, flags and address at the inputs
	input logic [48:0] snoop_sample, // The same fields at the snoop outputs
	input logic        count_enable,
	input logic        count_clear,
	input logic [perf_pkg::num_events*perf_pkg::counter_width-1:0] counts
);

	int failures = 0;

	snoop_delay: assert property (@(posedge clk) disable iff (!rst_n)
		snoop_sample == $past(in_sample, 2))
		else begin
			failures++;
			$error("snoop outputs differ from their inputs two cycles earlier");
		end

	counts_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!count_enable && !count_clear) |=> $stable(counts))
		else begin
			failures++;
			$error("counts changed while counting was disabled");
		end

	counts_cleared: assert property (@(posedge clk) disable iff (!rst_n)
		count_clear |=> (counts == '0))
		else begin
			failures++;
			$error("counts not zero after a clear");
		end

endmodule

bind perf_snoop perf_asserts snoop_checks (
	.clk(clk),
	.rst_n(rst_n),
	.in_sample({in_left_valid, out_left_ready, in_right_valid, in_right_ready,
		local_read, local_write, mem_waitrequest,
		in_left_ttl, in_left_read, in_left_inval, in_left_reply,
		in_right_ttl, in_right_read, in_right_inval, in_right_reply, mem_address}),
	.snoop_sample({snoop_left_valid, snoop_left_ready, snoop_right_valid, snoop_right_ready,
		snoop_read, snoop_write, snoop_waitrequest,
		snoop_left_ttl, snoop_left_read, snoop_left_inval, snoop_left_reply,
		snoop_right_ttl, snoop_right_read, snoop_right_inval, snoop_right_reply, snoop_address}),
	.count_enable(1'b1),
	.count_clear(1'b0),
	.counts('0)
);

bind perf_event_counter perf_asserts counter_checks (
	.clk(clk),
	.rst_n(rst_n),
	.in_sample('0),
	.snoop_sample('0),
	.count_enable(count_enable),
	.count_clear(count_clear),
	.counts(counts)
);

// File: testbench/perf_clock_gen.sv
module perf_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // Period of 40
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#5 rst_n = 1'b1; // Released off the edge like every other input
	end

endmodule

// File: testbench/perf_tb.sv
module perf_tb;

	logic clk;
	logic rst_n;

	logic                                in_left_valid, in_left_read, in_left_inval, in_left_reply;
	logic [perf_pkg::ttl_width-1:0]      in_left_ttl;
	logic [perf_pkg::line_ptr_width-1:0] in_left_address;
	logic                                in_left_ready, out_left_ready, out_left_valid;
	logic [perf_pkg::ttl_width-1:0]      out_left_ttl;
	logic                                out_left_read, out_left_inval, out_left_reply;
	logic [perf_pkg::line_ptr_width-1:0] out_left_address;
	logic                                in_right_valid, in_right_ready;
	logic [perf_pkg::ttl_width-1:0]      in_right_ttl;
	logic                                in_right_read, in_right_inval, in_right_reply;
	logic [perf_pkg::line_ptr_width-1:0] local_address;
	logic                                local_read, local_write, local_waitrequest;
	logic [perf_pkg::line_width-1:0]     local_writedata, local_readdata;
	logic [perf_pkg::be_width-1:0]       local_byteenable, mem_byteenable;
	logic                                mem_waitrequest, mem_read, mem_write;
	logic [perf_pkg::line_width-1:0]     mem_readdata, mem_writedata;
	logic [perf_pkg::word_width-1:0]     mem_address;
	logic [perf_pkg::csr_addr_width-1:0] csr_address;
	logic                                csr_read, csr_write;
	logic [perf_pkg::word_width-1:0]     csr_writedata, csr_readdata;

	int    errors;
	int    errors_at_start;
	int    tests_run;
	int    tests_failed;
	string test_name;

	// Reference counters fed from the driven inputs
	logic [perf_pkg::counter_width-1:0] model_count [perf_pkg::num_events];
	logic [perf_pkg::word_width-1:0]    model_last_addr;
	logic                               model_enable;

	perf_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

	perf_monitor dut (.*);

	// ==============================
	// Compare and report
	// ==============================

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_word(input string what, input logic [perf_pkg::word_width-1:0] expected,
		input logic [perf_pkg::word_width-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_line(input string what, input logic [perf_pkg::line_width-1:0] expected,
		input logic [perf_pkg::line_width-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test;
		if (errors == errors_at_start) begin
			$display("[PASS] %s", test_name);
		end else begin
			tests_failed++;
			$display("test %s finished with %0d mismatches", test_name, errors - errors_at_start);
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================

	task automatic drive_idle;
		{in_left_valid, in_left_read, in_left_inval, in_left_reply, in_left_ttl} = '0;
		{in_right_valid, in_right_ready, in_right_read, in_right_inval, in_right_reply} = '0;
		{in_right_ttl, out_left_ready, in_left_address, local_address} = '0;
		{local_read, local_write, local_writedata, local_byteenable} = '0;
		{mem_waitrequest, mem_readdata} = '0;
	endtask

	task automatic drive_random;
		in_left_valid    = $urandom_range(0, 1);
		in_left_ttl      = $urandom;
		{in_left_read, in_left_inval, in_left_reply} = $urandom;
		in_left_address  = $urandom;
		out_left_ready   = $urandom_range(0, 1);
		in_right_valid   = $urandom_range(0, 1);
		in_right_ready   = $urandom_range(0, 1);
		in_right_ttl     = $urandom;
		{in_right_read, in_right_inval, in_right_reply} = $urandom;
		local_address    = $urandom;
		local_read       = $urandom_range(0, 1);
		local_write      = $urandom_range(0, 1);
		local_writedata  = {$urandom, $urandom, $urandom, $urandom};
		local_byteenable = $urandom;
		mem_waitrequest  = $urandom_range(0, 1);
		mem_readdata     = {$urandom, $urandom, $urandom, $urandom};
	endtask

	// Ring transfer is valid and ready, memory access is a request without waitrequest
	task automatic model_step;
		logic lx;
		logic rx;
		logic busy;
		lx = in_left_valid && out_left_ready;
		rx = in_right_valid && in_right_ready;
		busy = local_read || local_write;
		if (model_enable) begin
			model_count[perf_pkg::ev_left_xfer]  += 32'(lx);
			model_count[perf_pkg::ev_left_stall] += 32'(in_left_valid && !out_left_ready);
			model_count[perf_pkg::ev_right_xfer] += 32'(rx);
			model_count[perf_pkg::ev_ring_read]  += 32'(lx && in_left_read)
				+ 32'(rx && in_right_read);
			model_count[perf_pkg::ev_ring_inval] += 32'(lx && in_left_inval)
				+ 32'(rx && in_right_inval);
			model_count[perf_pkg::ev_ring_reply] += 32'(lx && in_left_reply)
				+ 32'(rx && in_right_reply);
			model_count[perf_pkg::ev_mem_access] += 32'(busy && !mem_waitrequest);
			model_count[perf_pkg::ev_mem_wait]   += 32'(busy && mem_waitrequest);
			if (busy && !mem_waitrequest) begin
				model_last_addr = {local_address, 4'b0000}; // 16 bytes per line
			end
		end
	endtask

	task automatic check_passthrough;
		check_bit("in_left_ready", out_left_ready, in_left_ready);
		check_bit("out_left_valid", in_left_valid, out_left_valid);
		check_word("out_left_ttl", in_left_ttl, out_left_ttl);
		check_bit("out_left_read", in_left_read, out_left_read);
		check_bit("out_left_inval", in_left_inval, out_left_inval);
		check_bit("out_left_reply", in_left_reply, out_left_reply);
		check_word("out_left_address", in_left_address, out_left_address);
		check_bit("mem_read", local_read, mem_read);
		check_bit("mem_write", local_write, mem_write);
		check_line("mem_writedata", local_writedata, mem_writedata);
		check_word("mem_byteenable", local_byteenable, mem_byteenable);
		check_word("mem_address", {local_address, 4'b0000}, mem_address);
		check_line("local_readdata", mem_readdata, local_readdata);
		check_bit("local_waitrequest", mem_waitrequest, local_waitrequest);
	endtask

	task automatic wait_cycles(input int n);
		int waited;
		waited = 0;
		while (waited < n) begin
			@(posedge clk);
			waited++;
		end
	endtask

	task automatic run_phase(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#5 drive_random();
			model_step();
			#10 check_passthrough(); // Sampled well before the next edge
		end
		@(posedge clk);
		#5 drive_idle();
		wait_cycles(6); // Lets the last events pass both sampling stages
	endtask

	// ==============================
	// Register port
	// ==============================

	task automatic write_reg(input logic [perf_pkg::csr_addr_width-1:0] addr,
		input logic [perf_pkg::word_width-1:0] data);
		@(posedge clk);
		#5 csr_address = addr;
		csr_writedata = data;
		csr_write = 1'b1;
		@(posedge clk);
		#5 csr_write = 1'b0;
	endtask

	// Read data arrives one cycle after the strobe
	task automatic read_reg(input logic [perf_pkg::csr_addr_width-1:0] addr,
		output logic [perf_pkg::word_width-1:0] data);
		@(posedge clk);
		#5 csr_address = addr;
		csr_read = 1'b1;
		wait_cycles(1);
		#5 csr_read = 1'b0;
		data = csr_readdata;
	endtask

	task automatic check_registers;
		logic [perf_pkg::word_width-1:0] data;
		for (int i = 0; i < perf_pkg::num_events; i++) begin
			read_reg(perf_pkg::csr_counter_base + 4'(i), data);
			check_word($sformatf("count[%0d]", i), model_count[i], data);
		end
		read_reg(perf_pkg::csr_last_addr, data);
		check_word("last_address", model_last_addr, data);
	endtask

	// ==============================
	// Sequence
	// ==============================

	initial begin
		logic [perf_pkg::word_width-1:0] data;
		int waited;
		void'($urandom(32'h60fdaca0));
		{errors, errors_at_start, tests_run, tests_failed} = '0;
		test_name = "reset";
		drive_idle();
		{csr_address, csr_read, csr_write, csr_writedata} = '0;
		for (int i = 0; i < perf_pkg::num_events; i++) begin
			model_count[i] = '0;
		end
		model_last_addr = '0;
		model_enable = 1'b0;

		waited = 0;
		while (!rst_n && waited < 50) begin
			@(posedge clk);
			waited++;
		end
		if (!rst_n) begin
			errors++;
			$display("reset was never released");
		end

		write_reg(perf_pkg::csr_ctrl, 32'h1);
		model_enable = 1'b1;
		begin_test("passthrough_enabled");
		run_phase(300);
		end_test();

		begin_test("counters_enabled");
		for (int i = 0; i < perf_pkg::num_events; i++) begin
			read_reg(perf_pkg::csr_counter_base + 4'(i), data);
			check_word($sformatf("count[%0d]", i), model_count[i], data);
		end
		end_test();

		begin_test("last_address");
		read_reg(perf_pkg::csr_last_addr, data);
		check_word("last_address", model_last_addr, data);
		end_test();

		write_reg(perf_pkg::csr_ctrl, 32'h0);
		model_enable = 1'b0;
		begin_test("counters_disabled");
		run_phase(300);
		check_registers();
		end_test();

		begin_test("clear_and_map");
		write_reg(perf_pkg::csr_ctrl, 32'h3); // Enable stays set, clear fires once
		for (int i = 0; i < perf_pkg::num_events; i++) begin
			model_count[i] = '0;
		end
		model_last_addr = '0;
		model_enable = 1'b1;
		check_registers();
		read_reg(perf_pkg::csr_ctrl, data);
		check_word("ctrl", 32'h1, data);
		check_bit("ctrl clear bit", 1'b0, data[perf_pkg::ctrl_clear_bit]);
		read_reg(4'hc, data);
		check_word("unmapped", 32'h0, data);
		end_test();

		waited = dut.snoop.snoop_checks.failures + dut.counter.counter_checks.failures;
		if (waited != 0) begin
			errors += waited;
			$display("concurrent assertions failed %0d times", waited);
		end

		$display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#200000; // About 5000 cycles and far beyond a normal run
		$display("timeout: the run did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
